/* logic/mem_map_config.svh */
`ifndef MEM_MAP_CONFIG_SVH
`define MEM_MAP_CONFIG_SVH

// ========================================
// Bus widths and port counts
// ========================================
`define MEM_ADDR_W     16
`define MEM_DATA_W     8
`define MEM_N_MASTERS  4
`define MEM_N_SLAVES   6

// ========================================
// Address map, LO inclusive and HI exclusive
// ========================================
`define MEM_CART_LO    16'h0000
`define MEM_CART_HI    16'h8000
`define MEM_LCDRAM_LO  16'h8000
`define MEM_LCDRAM_HI  16'hA000
`define MEM_WRAM_LO    16'hC000
`define MEM_WRAM_HI    16'hE000
`define MEM_OAM_LO     16'hFE00   // Sprite attribute table
`define MEM_OAM_HI     16'hFEA0
`define MEM_IOREG_LO   16'hFF00
`define MEM_IOREG_HI   16'hFF80
`define MEM_LWRAM_LO   16'hFF80
`define MEM_LWRAM_HI   16'hFFFF   // Top byte stays unmapped

// Gaps at A000, E000, FEA0 and FFFF decode to no region

`endif

/* logic/mem_router_pkg.sv */
`include "mem_map_config.svh"

package mem_router_pkg;

   // Master index doubles as priority rank, lowest wins
   typedef enum logic [1:0] {
      MST_CPU  = 2'd0,
      MST_PPU  = 2'd1,
      MST_RDMA = 2'd2,
      MST_WDMA = 2'd3
   } master_e;

   typedef enum logic [2:0] {
      SLV_CART   = 3'd0,
      SLV_LCDRAM = 3'd1,
      SLV_WRAM   = 3'd2,
      SLV_OAM    = 3'd3,
      SLV_IOREG  = 3'd4,
      SLV_LWRAM  = 3'd5
   } slave_e;

   typedef logic [`MEM_ADDR_W-1:0]    addr_t;
   typedef logic [`MEM_DATA_W-1:0]    data_t;
   typedef logic [`MEM_N_MASTERS-1:0] master_vec_t;   // One bit per master

   typedef struct packed {
      addr_t addr;
      data_t wdata;
      logic  we_l;
      logic  re_l;
   } master_req_t;

   // Request as presented to one region
   typedef struct packed {
      addr_t addr;
      data_t wdata;
      logic  we_l;
      logic  re_l;
   } slave_req_t;

   typedef struct packed {
      logic same_port_access;
      logic ppu_boundary;
      logic rdma_boundary;
      logic wdma_boundary;
   } error_flags_t;

   // CPU and PPU use either strobe, RDMA only reads and WDMA only writes
   function automatic master_vec_t active_masters(
      input master_req_t [`MEM_N_MASTERS-1:0] req
   );
      master_vec_t act;
      act[MST_CPU]  = ~req[MST_CPU].we_l | ~req[MST_CPU].re_l;
      act[MST_PPU]  = ~req[MST_PPU].we_l | ~req[MST_PPU].re_l;
      act[MST_RDMA] = ~req[MST_RDMA].re_l;
      act[MST_WDMA] = ~req[MST_WDMA].we_l;
      return act;
   endfunction

endpackage

/* logic/address_decoder.sv */
`timescale 1ns/100ps
`include "mem_map_config.svh"

module address_decoder (
   input  mem_router_pkg::master_req_t [`MEM_N_MASTERS-1:0] mst_req,
   output mem_router_pkg::master_vec_t [`MEM_N_SLAVES-1:0]  hit
);

   mem_router_pkg::master_vec_t active;

   // Half-open range check against one region of the map
   function automatic logic in_region(
      input mem_router_pkg::addr_t  addr,
      input mem_router_pkg::slave_e slv
   );
      mem_router_pkg::addr_t lo;
      mem_router_pkg::addr_t hi;
      case (slv)
         mem_router_pkg::SLV_CART: begin
            lo = `MEM_CART_LO;
            hi = `MEM_CART_HI;
         end
         mem_router_pkg::SLV_LCDRAM: begin
            lo = `MEM_LCDRAM_LO;
            hi = `MEM_LCDRAM_HI;
         end
         mem_router_pkg::SLV_WRAM: begin
            lo = `MEM_WRAM_LO;
            hi = `MEM_WRAM_HI;
         end
         mem_router_pkg::SLV_OAM: begin
            lo = `MEM_OAM_LO;
            hi = `MEM_OAM_HI;
         end
         mem_router_pkg::SLV_IOREG: begin
            lo = `MEM_IOREG_LO;
            hi = `MEM_IOREG_HI;
         end
         mem_router_pkg::SLV_LWRAM: begin
            lo = `MEM_LWRAM_LO;
            hi = `MEM_LWRAM_HI;
         end
         default: begin   // Empty range
            lo = '0;
            hi = '0;
         end
      endcase
      return (addr >= lo) && (addr < hi);
   endfunction

   assign active = mem_router_pkg::active_masters(mst_req);

   always_comb begin
      for (int s = 0; s < `MEM_N_SLAVES; s++) begin
         for (int m = 0; m < `MEM_N_MASTERS; m++) begin
            hit[s][m] = active[m] &
                        in_region(mst_req[m].addr, mem_router_pkg::slave_e'(s));
         end
      end
   end

endmodule

/* logic/slave_port_mux.sv */
`timescale 1ns/100ps
`include "mem_map_config.svh"

module slave_port_mux (
   input  mem_router_pkg::master_vec_t                      hit,
   input  mem_router_pkg::master_req_t [`MEM_N_MASTERS-1:0] mst_req,
   output mem_router_pkg::slave_req_t                       slv_req,
   output mem_router_pkg::master_vec_t                      grant
);

   // ========================================
   // Fixed priority grant
   // ========================================

   // Isolate the lowest set bit, so CPU beats PPU beats RDMA beats WDMA
   assign grant = hit & (~hit + 1'b1);

   // ========================================
   // Request forwarding
   // ========================================

   always_comb begin
      // Idle port
      slv_req.addr  = '0;
      slv_req.wdata = '0;
      slv_req.we_l  = 1'b1;
      slv_req.re_l  = 1'b1;

      for (int m = 0; m < `MEM_N_MASTERS; m++) begin
         if (grant[m]) begin
            slv_req.addr  = mst_req[m].addr;
            slv_req.wdata = mst_req[m].wdata;
            slv_req.we_l  = mst_req[m].we_l;
            slv_req.re_l  = mst_req[m].re_l;
         end
      end

      // DMA ports drive only their own strobe
      if (grant[mem_router_pkg::MST_RDMA]) begin
         slv_req.we_l = 1'b1;
      end
      if (grant[mem_router_pkg::MST_WDMA]) begin
         slv_req.re_l = 1'b1;
      end
   end

endmodule

/* logic/read_return_mux.sv */
`timescale 1ns/100ps
`include "mem_map_config.svh"

module read_return_mux (
   input  mem_router_pkg::master_vec_t [`MEM_N_SLAVES-1:0]  grant,
   input  mem_router_pkg::master_req_t [`MEM_N_MASTERS-1:0] mst_req,
   input  mem_router_pkg::data_t       [`MEM_N_SLAVES-1:0]  slv_rdata,
   output mem_router_pkg::data_t       [`MEM_N_MASTERS-1:0] mst_rdata
);

   mem_router_pkg::master_vec_t rd_en;   // Master is reading this cycle

   always_comb begin
      rd_en[mem_router_pkg::MST_CPU]  = ~mst_req[mem_router_pkg::MST_CPU].re_l;
      rd_en[mem_router_pkg::MST_PPU]  = ~mst_req[mem_router_pkg::MST_PPU].re_l;
      rd_en[mem_router_pkg::MST_RDMA] = ~mst_req[mem_router_pkg::MST_RDMA].re_l;
      rd_en[mem_router_pkg::MST_WDMA] = 1'b0;   // Write-only port
   end

   // ========================================
   // AND-OR return path
   // ========================================

   // A master's address decodes to one region at most, so the OR picks
   // a single word or leaves zero
   always_comb begin
      mst_rdata = '0;
      for (int m = 0; m < `MEM_N_MASTERS; m++) begin
         for (int s = 0; s < `MEM_N_SLAVES; s++) begin
            if (grant[s][m] && rd_en[m]) begin
               mst_rdata[m] = mst_rdata[m] | slv_rdata[s];
            end
         end
      end
   end

endmodule

/* logic/access_error_monitor.sv */
`timescale 1ns/100ps
`include "mem_map_config.svh"

module access_error_monitor (
   input  logic                                             clk,
   input  logic                                             arst_n,
   input  mem_router_pkg::master_vec_t [`MEM_N_SLAVES-1:0]  hit,
   input  mem_router_pkg::master_req_t [`MEM_N_MASTERS-1:0] mst_req,
   output mem_router_pkg::error_flags_t                     err
);

   mem_router_pkg::master_vec_t  active;
   mem_router_pkg::master_vec_t  mapped;      // Master hits some region
   logic                         collision;
   logic                         ppu_video;   // PPU inside LCD RAM or OAM
   mem_router_pkg::error_flags_t err_now;

   assign active = mem_router_pkg::active_masters(mst_req);

   // ========================================
   // Error conditions
   // ========================================

   always_comb begin
      mapped    = '0;
      collision = 1'b0;
      for (int s = 0; s < `MEM_N_SLAVES; s++) begin
         mapped    = mapped | hit[s];
         collision = collision | ((hit[s] & (hit[s] - 1'b1)) != '0);  // Two or more
      end
   end

   assign ppu_video = hit[mem_router_pkg::SLV_LCDRAM][mem_router_pkg::MST_PPU] |
                      hit[mem_router_pkg::SLV_OAM][mem_router_pkg::MST_PPU];

   always_comb begin
      err_now.same_port_access = collision;
      err_now.ppu_boundary     = active[mem_router_pkg::MST_PPU] & ~ppu_video;
      err_now.rdma_boundary    = active[mem_router_pkg::MST_RDMA] &
                                 ~mapped[mem_router_pkg::MST_RDMA];
      err_now.wdma_boundary    = active[mem_router_pkg::MST_WDMA] &
                                 ~mapped[mem_router_pkg::MST_WDMA];
   end

   // ========================================
   // Sticky flags
   // ========================================

   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         err <= '0;
      end else begin
         err <= err | err_now;   // Held until reset
      end
   end

endmodule

/* logic/memory_router.sv */
`timescale 1ns/100ps
`include "mem_map_config.svh"

module memory_router (
   input  logic                                             clk,
   input  logic                                             arst_n,

   // Master side, indexed by master_e
   input  mem_router_pkg::master_req_t [`MEM_N_MASTERS-1:0] mst_req,
   output mem_router_pkg::data_t       [`MEM_N_MASTERS-1:0] mst_rdata,

   // Region side, indexed by slave_e
   output mem_router_pkg::slave_req_t  [`MEM_N_SLAVES-1:0]  slv_req,
   input  mem_router_pkg::data_t       [`MEM_N_SLAVES-1:0]  slv_rdata,

   output mem_router_pkg::error_flags_t                     err
);

   mem_router_pkg::master_vec_t [`MEM_N_SLAVES-1:0] hit;     // Requests per region
   mem_router_pkg::master_vec_t [`MEM_N_SLAVES-1:0] grant;   // Winner per region

   // ========================================
   // Address decode
   // ========================================

   address_decoder address_decoder_inst (
      .mst_req (mst_req),
      .hit     (hit)
   );

   // ========================================
   // One arbiter and forward mux per region
   // ========================================

   for (genvar s = 0; s < `MEM_N_SLAVES; s++) begin : g_slave_port
      slave_port_mux slave_port_mux_inst (
         .hit     (hit[s]),
         .mst_req (mst_req),
         .slv_req (slv_req[s]),
         .grant   (grant[s])
      );
   end

   // ========================================
   // Read data back to the masters
   // ========================================

   read_return_mux read_return_mux_inst (
      .grant     (grant),
      .mst_req   (mst_req),
      .slv_rdata (slv_rdata),
      .mst_rdata (mst_rdata)
   );

   // Collision and out-of-map flags
   access_error_monitor access_error_monitor_inst (
      .clk     (clk),
      .arst_n  (arst_n),
      .hit     (hit),
      .mst_req (mst_req),
      .err     (err)
   );

endmodule

/* dv/memory_router_tb.sv */
`timescale 1ns/100ps
`include "mem_map_config.svh"

module memory_router_tb;

   localparam int N_CYCLES       = 3000;
   localparam int RESET_CYCLES   = 10;
   localparam int RESET_TIMEOUT  = 50;
   localparam int RESET_INTERVAL = 25;   // Cycles between short reset pulses

   logic                                             clk;
   logic                                             arst_n;
   mem_router_pkg::master_req_t [`MEM_N_MASTERS-1:0] mst_req;
   mem_router_pkg::data_t       [`MEM_N_MASTERS-1:0] mst_rdata;
   mem_router_pkg::slave_req_t  [`MEM_N_SLAVES-1:0]  slv_req;
   mem_router_pkg::data_t       [`MEM_N_SLAVES-1:0]  slv_rdata;
   mem_router_pkg::error_flags_t                     err;

   integer                       seed;
   mem_router_pkg::error_flags_t exp_err;    // Model of the sticky flags
   mem_router_pkg::error_flags_t next_err;   // Value they take at the next edge

   memory_router memory_router_inst (
      .clk       (clk),
      .arst_n    (arst_n),
      .mst_req   (mst_req),
      .mst_rdata (mst_rdata),
      .slv_req   (slv_req),
      .slv_rdata (slv_rdata),
      .err       (err)
   );

   always #4 clk = ~clk;

   // ========================================
   // Reference model
   // ========================================

   function automatic logic model_active(input mem_router_pkg::master_req_t req, input int m);
      if (m == int'(mem_router_pkg::MST_RDMA)) begin
         return !req.re_l;
      end else if (m == int'(mem_router_pkg::MST_WDMA)) begin
         return !req.we_l;
      end
      return !req.we_l || !req.re_l;
   endfunction

   // Region index for an address, -1 when unmapped
   function automatic int model_region(input mem_router_pkg::addr_t a);
      if (a >= `MEM_CART_LO && a < `MEM_CART_HI) return int'(mem_router_pkg::SLV_CART);
      if (a >= `MEM_LCDRAM_LO && a < `MEM_LCDRAM_HI) return int'(mem_router_pkg::SLV_LCDRAM);
      if (a >= `MEM_WRAM_LO && a < `MEM_WRAM_HI) return int'(mem_router_pkg::SLV_WRAM);
      if (a >= `MEM_OAM_LO && a < `MEM_OAM_HI) return int'(mem_router_pkg::SLV_OAM);
      if (a >= `MEM_IOREG_LO && a < `MEM_IOREG_HI) return int'(mem_router_pkg::SLV_IOREG);
      if (a >= `MEM_LWRAM_LO && a < `MEM_LWRAM_HI) return int'(mem_router_pkg::SLV_LWRAM);
      return -1;
   endfunction

   // ========================================
   // Compare tasks
   // ========================================

   task automatic stop_on_failure();
      $display("ERRORS FOUND");
      $fatal(1, "simulation stopped at the first failure");
   endtask

   task automatic check_slave_req(input string name, input mem_router_pkg::slave_req_t got,
                                  input mem_router_pkg::slave_req_t expected);
      if (got !== expected) begin
         $display("error: time %0t, signal %s, got %h, expected %h",
                  $time, name, got, expected);
         stop_on_failure();
      end
   endtask

   task automatic check_data(input string name, input mem_router_pkg::data_t got,
                             input mem_router_pkg::data_t expected);
      if (got !== expected) begin
         $display("error: time %0t, signal %s, got %h, expected %h",
                  $time, name, got, expected);
         stop_on_failure();
      end
   endtask

   task automatic check_err(input string name, input mem_router_pkg::error_flags_t got,
                            input mem_router_pkg::error_flags_t expected);
      if (got !== expected) begin
         $display("error: time %0t, signal %s, got %b, expected %b",
                  $time, name, got, expected);
         stop_on_failure();
      end
   endtask

   // ========================================
   // Stimulus
   // ========================================

   task automatic drive_idle();
      logic [31:0] r;
      for (int m = 0; m < `MEM_N_MASTERS; m++) begin
         mst_req[m].addr  = '0;
         mst_req[m].wdata = '0;
         mst_req[m].we_l  = 1'b1;
         mst_req[m].re_l  = 1'b1;
      end
      for (int s = 0; s < `MEM_N_SLAVES; s++) begin
         r = $random(seed);
         slv_rdata[s] = r[`MEM_DATA_W-1:0];
      end
   endtask

   // Half of the addresses land inside a mapped region
   task automatic draw_request(output mem_router_pkg::master_req_t req);
      logic [31:0]           r;
      logic [31:0]           r_addr;
      logic [31:0]           sel;
      mem_router_pkg::addr_t lo;
      mem_router_pkg::addr_t hi;
      r      = $random(seed);
      r_addr = $random(seed);
      sel    = {$random(seed)} % 6;
      case (sel)
         0: begin
            lo = `MEM_CART_LO;
            hi = `MEM_CART_HI;
         end
         1: begin
            lo = `MEM_LCDRAM_LO;
            hi = `MEM_LCDRAM_HI;
         end
         2: begin
            lo = `MEM_WRAM_LO;
            hi = `MEM_WRAM_HI;
         end
         3: begin
            lo = `MEM_OAM_LO;
            hi = `MEM_OAM_HI;
         end
         4: begin
            lo = `MEM_IOREG_LO;
            hi = `MEM_IOREG_HI;
         end
         default: begin
            lo = `MEM_LWRAM_LO;
            hi = `MEM_LWRAM_HI;
         end
      endcase
      if (r[0]) begin
         req.addr = lo + (r_addr[`MEM_ADDR_W-1:0] % (hi - lo));
      end else begin
         req.addr = r_addr[`MEM_ADDR_W-1:0];
      end
      req.we_l  = r[1];
      req.re_l  = r[2];
      req.wdata = r[`MEM_DATA_W+2:3];
   endtask

   task automatic drive_random_inputs();
      mem_router_pkg::master_req_t req;
      logic [31:0]                 r;
      for (int m = 0; m < `MEM_N_MASTERS; m++) begin
         draw_request(req);
         mst_req[m] = req;
      end
      for (int s = 0; s < `MEM_N_SLAVES; s++) begin
         r = $random(seed);
         slv_rdata[s] = r[`MEM_DATA_W-1:0];
      end
   endtask

   // ========================================
   // Checking
   // ========================================

   task automatic check_outputs();
      logic                         act [`MEM_N_MASTERS];
      int                           region [`MEM_N_MASTERS];
      mem_router_pkg::data_t        exp_rdata [`MEM_N_MASTERS];
      mem_router_pkg::slave_req_t   exp_req;
      mem_router_pkg::error_flags_t now_err;
      int                           winner;
      int                           n_hits;
      int                           ppu;
      ppu     = int'(mem_router_pkg::MST_PPU);
      now_err = '0;
      for (int m = 0; m < `MEM_N_MASTERS; m++) begin
         act[m]       = model_active(mst_req[m], m);
         region[m]    = act[m] ? model_region(mst_req[m].addr) : -1;
         exp_rdata[m] = '0;
      end
      for (int s = 0; s < `MEM_N_SLAVES; s++) begin
         winner = -1;
         n_hits = 0;
         for (int m = 0; m < `MEM_N_MASTERS; m++) begin
            if (region[m] == s) begin
               n_hits++;
               if (winner < 0) winner = m;   // Lowest index wins
            end
         end
         if (n_hits > 1) now_err.same_port_access = 1'b1;
         exp_req = '{addr: '0, wdata: '0, we_l: 1'b1, re_l: 1'b1};
         if (winner >= 0) begin
            exp_req.addr  = mst_req[winner].addr;
            exp_req.wdata = mst_req[winner].wdata;
            exp_req.we_l  = mst_req[winner].we_l;
            exp_req.re_l  = mst_req[winner].re_l;
            if (winner == int'(mem_router_pkg::MST_RDMA)) exp_req.we_l = 1'b1;
            if (winner == int'(mem_router_pkg::MST_WDMA)) exp_req.re_l = 1'b1;
            if (!mst_req[winner].re_l && winner != int'(mem_router_pkg::MST_WDMA)) begin
               exp_rdata[winner] = slv_rdata[s];
            end
         end
         check_slave_req($sformatf("slv_req[%0d]", s), slv_req[s], exp_req);
      end
      for (int m = 0; m < `MEM_N_MASTERS; m++) begin
         check_data($sformatf("mst_rdata[%0d]", m), mst_rdata[m], exp_rdata[m]);
      end
      check_err("err", err, exp_err);

      // PPU belongs in LCD RAM or OAM only
      now_err.ppu_boundary  = act[ppu] &&
                              region[ppu] != int'(mem_router_pkg::SLV_LCDRAM) &&
                              region[ppu] != int'(mem_router_pkg::SLV_OAM);
      now_err.rdma_boundary = act[int'(mem_router_pkg::MST_RDMA)] &&
                              region[int'(mem_router_pkg::MST_RDMA)] < 0;
      now_err.wdma_boundary = act[int'(mem_router_pkg::MST_WDMA)] &&
                              region[int'(mem_router_pkg::MST_WDMA)] < 0;
      next_err = exp_err | now_err;
   endtask

   // ========================================
   // Reset and main sequence
   // ========================================

   initial begin
      arst_n = 1'b0;
      for (int i = 0; i < RESET_CYCLES; i++) begin
         @(posedge clk);
      end
      #1 arst_n = 1'b1;
   end

   initial begin
      int cycles;
      seed        = 32'h99e;
      clk         = 1'b0;
      exp_err     = '0;
      next_err    = '0;
      drive_idle();

      cycles = 0;
      while (arst_n !== 1'b1) begin
         @(posedge clk);
         cycles++;
         if (cycles > RESET_TIMEOUT) begin
            $display("reset was not released within %0d clock cycles", RESET_TIMEOUT);
            stop_on_failure();
         end
      end

      // First cycle out of reset with every master idle
      #1 drive_idle();
      #6 check_outputs();

      for (int c = 0; c < N_CYCLES; c++) begin
         @(posedge clk);
         exp_err = next_err;
         if (c % RESET_INTERVAL == RESET_INTERVAL - 1) begin
            // Short reset pulse clears the sticky flags
            #1 arst_n = 1'b0;
            drive_idle();
            exp_err = '0;
            #6 check_outputs();
         end else begin
            #1 arst_n = 1'b1;
            drive_random_inputs();
            #6 check_outputs();   // Just before the next edge
         end
      end

      $display("NO ERRORS");
      $finish;
   end

endmodule

/* sources.f */
+incdir+logic
logic/mem_router_pkg.sv
logic/address_decoder.sv
logic/slave_port_mux.sv
logic/read_return_mux.sv
logic/access_error_monitor.sv
logic/memory_router.sv
dv/memory_router_tb.sv

/* Makefile */
# Verilator build and run of the memory router testbench

TOP := memory_router_tb

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  help   list the targets"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove the build output"

# Exit status of the simulation binary is the test result
test:
	verilator --binary --timing -Wno-fatal --top-module $(TOP) \
		-f sources.f -Mdir obj_dir -o V$(TOP)
	./obj_dir/V$(TOP)

clean:
	rm -rf obj_dir
